//--- verif/program_trace.txt
# kind addr data err: W writes, R reads and compares, err is the expected pslverr
# P polls control until run is 0, X n holds reset for n cycles; addr and data in hex
# host access to both memories while halted
W 800 a5a51234 0
W 804 11112222 0
W 810 cafe0001 0
W 838 12345678 0
R 800 a5a51234 0
R 804 11112222 0
R 000 00000000 0
# alu program: movi, addi, ori, xori, add, sub, and, or, xor, srli, slli, rotri, break
W 400 44112345 0
W 404 44280001 0
W 408 5030fffb 0
W 40c 58417f00 0
W 410 5650c321 0
W 414 40608800 0
W 418 40708c01 0
W 41c 40821402 0
W 420 40919c04 0
W 424 40a11803 0
W 428 40b20809 0
W 42c 40c40408 0
W 430 40d2080b 0
W 434 4000000a 0
R 400 44112345 0
R 434 4000000a 0
W 000 00000001 0
P
R 000 00000000 0
R c04 00012345 0
R c08 fff80001 0
R c0c 00012340 0
R c10 fff87f01 0
R c14 00016064 0
R c18 fff92346 0
R c1c 00000005 0
R c20 00006000 0
R c24 00012345 0
R c28 00012347 0
R c2c 0fff8000 0
R c30 01234500 0
R c34 1fff8000 0
# load and store program: swi, lwi, sw, lw, break
W 400 44100020 0
W 404 44200003 0
W 408 4435a5a5 0
W 40c 14308008 0
W 410 0440fff0 0
W 414 38408a0a 0
W 418 38508b02 0
W 41c 4000000a 0
W 000 00000001 0
P
R 828 0005a5a5 0
R 82c cafe0001 0
R c10 cafe0001 0
R c14 12345678 0
# accesses while running are refused
W 000 00000001 0
W 804 deadbeef 1
W 41c 00000000 1
R c10 00000000 1
R 800 00000000 1
P
R 804 11112222 0
R 41c 4000000a 0
R 000 00000000 0
# reset in the middle of a run
W 000 00000001 0
R c04 00000000 1
X 3
R 000 00000000 0
R c04 00000000 0
R c10 00000000 0
R c14 00000000 0

//--- files.f
hw/cpu_pkg.sv
hw/word_memory.sv
hw/cpu_regfile.sv
hw/cpu_alu.sv
hw/cpu_controller.sv
hw/apb_host_port.sv
hw/cpu_top.sv
verif/tb_cpu_top.sv

//--- run.sh
#!/bin/sh
verilator --binary -f files.f --top-module tb_cpu_top -o tb_cpu_top > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_cpu_top > sim.log 2>&1 || { echo "simulation did not finish, see sim.log"; exit 1; }
grep -q "Test failed" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; } || echo "simulation passed"

//--- verif/tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;

	logic clock;
	logic reset;
	cpu_pkg::apb_req_t apb_req;
	cpu_pkg::apb_rsp_t apb_rsp;

	int error_count = 0;
	int record_count = 0;
	bit trace_loaded;
	bit trace_ok;

	// one entry per trace record
	logic [7:0] kinds[$];
	logic [11:0] addrs[$];
	logic [31:0] datas[$];
	bit errs[$];

	cpu_top cpu_top_i (
		.clock(clock),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			error_count++;
			$display("** Error at %0t ns: %s: got %h, expected %h", $time, what, got, expected);
		end
	endtask

	// memory reads that the port accepts take one wait state
	function automatic int read_wait_states(input logic [11:0] addr, input bit err);
		if (err) begin
			return 0;
		end
		if (addr >= cpu_pkg::map_im && addr < cpu_pkg::map_reg) begin
			return 1;
		end
		return 0;
	endfunction

	task automatic load_trace(output bit ok);
		int fd;
		int c;
		int n;
		int e;
		logic [7:0] ch;
		logic [31:0] a;
		logic [31:0] d;
		ok = 1'b1;
		fd = $fopen("verif/program_trace.txt", "r");
		if (fd == 0) begin
			ok = 1'b0;
			return;
		end
		c = $fgetc(fd);
		while (c != -1 && ok) begin
			ch = c[7:0];
			if (ch == "#") begin
				while (c != -1 && c[7:0] != "\n") begin
					c = $fgetc(fd);
				end
			end else if (ch == "W" || ch == "R") begin
				n = $fscanf(fd, "%h %h %d", a, d, e);
				if (n != 3) begin
					ok = 1'b0;
				end else begin
					kinds.push_back(ch);
					addrs.push_back(a[11:0]);
					datas.push_back(d);
					errs.push_back(e != 0);
				end
			end else if (ch == "P") begin
				kinds.push_back(ch);
				addrs.push_back(12'h0);
				datas.push_back(32'h0);
				errs.push_back(1'b0);
			end else if (ch == "X") begin
				n = $fscanf(fd, "%d", e);
				if (n != 1) begin
					ok = 1'b0;
				end else begin
					kinds.push_back(ch);
					addrs.push_back(12'h0);
					datas.push_back(e);
					errs.push_back(1'b0);
				end
			end else if (ch != " " && ch != "\n" && ch != "\t" && ch != "\r") begin
				ok = 1'b0;
			end
			c = $fgetc(fd);
		end
		$fclose(fd);
	endtask

	// setup, access, then wait for pready sampled on the falling edge
	task automatic apb_access(input bit write, input logic [11:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output bit err,
		output int waits);
		cpu_pkg::apb_req_t req;
		req = '0;
		req.psel = 1'b1;
		req.pwrite = write;
		req.paddr = addr;
		req.pwdata = wdata;
		@(posedge clock);
		apb_req <= req;
		req.penable = 1'b1;
		@(posedge clock);
		apb_req <= req;
		waits = 0;
		@(negedge clock);
		while (!apb_rsp.pready) begin
			waits++;
			@(negedge clock);
		end
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		@(posedge clock);
		apb_req <= '0;
	endtask

	task automatic poll_run_clear();
		logic [31:0] rdata;
		bit err;
		int waits;
		rdata = 32'h1;
		while (rdata[0] !== 1'b0) begin
			apb_access(1'b0, cpu_pkg::map_ctrl, '0, rdata, err, waits);
			check_value("pslverr of control poll", {31'b0, err}, 32'h0);
		end
	endtask

	task automatic pulse_reset(input logic [31:0] cycles);
		@(posedge clock);
		reset <= 1'b1;
		repeat (cycles) @(posedge clock);
		reset <= 1'b0;
	endtask

	task automatic run_record(input int i);
		logic [31:0] rdata;
		bit err;
		int waits;
		case (kinds[i])
			"W": begin
				apb_access(1'b1, addrs[i], datas[i], rdata, err, waits);
				check_value($sformatf("pslverr of write %h", addrs[i]), {31'b0, err},
					{31'b0, errs[i]});
				check_value($sformatf("wait states of write %h", addrs[i]), waits, 0);
			end
			"R": begin
				apb_access(1'b0, addrs[i], '0, rdata, err, waits);
				check_value($sformatf("pslverr of read %h", addrs[i]), {31'b0, err},
					{31'b0, errs[i]});
				// read data means nothing on an error
				if (!errs[i]) begin
					check_value($sformatf("data of read %h", addrs[i]), rdata, datas[i]);
				end
				check_value($sformatf("wait states of read %h", addrs[i]), waits,
					read_wait_states(addrs[i], errs[i]));
			end
			"P": poll_run_clear();
			default: pulse_reset(datas[i]);
		endcase
	endtask

	initial begin
		reset <= 1'b1;
		apb_req <= '0;
		trace_loaded = 1'b0;
		load_trace(trace_ok);
		record_count = kinds.size();
		if (!trace_ok) begin
			$display("could not read the trace file verif/program_trace.txt");
			$display("Test failed");
			$finish;
		end else begin
			trace_loaded = 1'b1;
			repeat (8) @(posedge clock);
			reset <= 1'b0;
			for (int i = 0; i < record_count; i++) begin
				run_record(i);
			end
			repeat (2) @(posedge clock);
			$display("errors: %0d", error_count);
			if (error_count == 0) begin
				$display("Test completed successfully");
			end else begin
				$display("Test failed");
			end
			$finish;
		end
	end

	// budget of 200 cycles per record
	initial begin
		wait (trace_loaded);
		repeat (record_count * 200) @(posedge clock);
		$display("timeout: the trace did not finish within %0d clock cycles",
			record_count * 200);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
	input logic clock,
	input logic reset,
	input cpu_pkg::apb_req_t apb_req,
	output cpu_pkg::apb_rsp_t apb_rsp
);

	logic run;
	logic halt_done;
	cpu_pkg::mem_req_t host_im;
	cpu_pkg::mem_req_t host_dm;
	cpu_pkg::mem_req_t core_im;
	cpu_pkg::mem_req_t core_dm;
	logic [cpu_pkg::word_width-1:0] im_rdata;
	logic [cpu_pkg::word_width-1:0] dm_rdata;
	logic [4:0] reg_idx;
	logic [4:0] host_idx;
	logic [cpu_pkg::word_width-1:0] host_data;
	logic [cpu_pkg::word_width-1:0] pc;
	logic [cpu_pkg::word_width-1:0] ir;
	cpu_pkg::phase_e phase;
	cpu_pkg::ctrl_t ctrl;
	logic fetch_en;
	logic ir_load;
	logic pc_en;
	logic mem_en;
	logic [cpu_pkg::word_width-1:0] ra_data;
	logic [cpu_pkg::word_width-1:0] rb_data;
	logic [cpu_pkg::word_width-1:0] result;
	logic [cpu_pkg::word_width-1:0] mem_addr;
	logic wr_en;
	logic [cpu_pkg::word_width-1:0] wr_data;

	apb_host_port apb_host_port_i (
		.clock(clock), .reset(reset), .apb_req(apb_req), .halt_done(halt_done),
		.im_rdata(im_rdata), .dm_rdata(dm_rdata), .reg_data(host_data),
		.apb_rsp(apb_rsp), .run(run), .host_im(host_im), .host_dm(host_dm),
		.reg_idx(reg_idx)
	);

	// a new run always starts at address 0
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (!run) begin
			pc <= '0;
		end else if (pc_en) begin
			pc <= pc + 4;
		end
	end

	always_ff @(posedge clock) begin
		if (ir_load) begin
			ir <= im_rdata;
		end
	end

	always_comb begin
		core_im = '0;
		core_im.en = fetch_en;
		core_im.addr = pc[cpu_pkg::mem_addr_width+1:2];
		core_dm.en = mem_en;
		core_dm.we = ctrl.mem_write;
		core_dm.addr = mem_addr[cpu_pkg::mem_addr_width+1:2];
		// store data comes from rt on the host read port
		core_dm.wdata = host_data;
	end

	word_memory im_i (.clock(clock), .req(run ? core_im : host_im), .rdata(im_rdata));
	word_memory dm_i (.clock(clock), .req(run ? core_dm : host_dm), .rdata(dm_rdata));

	cpu_controller cpu_controller_i (
		.clock(clock), .reset(reset), .run(run), .instr(ir), .phase(phase), .ctrl(ctrl),
		.fetch_en(fetch_en), .ir_load(ir_load), .pc_en(pc_en), .mem_en(mem_en),
		.halt_done(halt_done)
	);

	assign host_idx = run ? ir[cpu_pkg::rt_msb:cpu_pkg::rt_lsb] : reg_idx;
	assign wr_en = run && ctrl.reg_write && phase == cpu_pkg::ph_writeback;
	assign wr_data = (ctrl.wb_sel == cpu_pkg::wb_load) ? dm_rdata : result;

	cpu_regfile cpu_regfile_i (
		.clock(clock), .reset(reset),
		.ra_idx(ir[cpu_pkg::ra_msb:cpu_pkg::ra_lsb]),
		.rb_idx(ir[cpu_pkg::rb_msb:cpu_pkg::rb_lsb]),
		.wr_idx(ir[cpu_pkg::rt_msb:cpu_pkg::rt_lsb]),
		.host_idx(host_idx), .wr_en(wr_en), .wr_data(wr_data),
		.ra_data(ra_data), .rb_data(rb_data), .host_data(host_data)
	);

	cpu_alu cpu_alu_i (
		.ctrl(ctrl), .ra_data(ra_data), .rb_data(rb_data), .ir(ir),
		.result(result), .mem_addr(mem_addr)
	);

endmodule

`default_nettype wire

//--- hw/apb_host_port.sv
`timescale 1ns/1ps
`default_nettype none

module apb_host_port (
	input logic clock,
	input logic reset,
	input cpu_pkg::apb_req_t apb_req,
	input logic halt_done,
	input logic [cpu_pkg::word_width-1:0] im_rdata,
	input logic [cpu_pkg::word_width-1:0] dm_rdata,
	input logic [cpu_pkg::word_width-1:0] reg_data,
	output cpu_pkg::apb_rsp_t apb_rsp,
	output logic run,
	output cpu_pkg::mem_req_t host_im,
	output cpu_pkg::mem_req_t host_dm,
	output logic [4:0] reg_idx
);

	logic access;
	logic hit_ctrl;
	logic hit_im;
	logic hit_dm;
	logic hit_reg;
	logic bad;
	logic mem_rd;
	logic rd_wait;

	assign access = apb_req.psel && apb_req.penable;

	assign hit_ctrl = apb_req.paddr == cpu_pkg::map_ctrl;
	assign hit_im = apb_req.paddr[11:10] == cpu_pkg::map_im[11:10];
	assign hit_dm = apb_req.paddr[11:10] == cpu_pkg::map_dm[11:10];
	assign hit_reg = apb_req.paddr[11:10] == cpu_pkg::map_reg[11:10]
		&& apb_req.paddr <= cpu_pkg::map_reg_last;

	// unmapped, or memory and registers while the core owns them
	assign bad = !(hit_ctrl || hit_im || hit_dm || hit_reg)
		|| (run && (hit_im || hit_dm || hit_reg));
	assign mem_rd = (hit_im || hit_dm) && !apb_req.pwrite && !bad;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			rd_wait <= 1'b0;
		end else begin
			rd_wait <= access && mem_rd && !rd_wait;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			run <= 1'b0;
		end else if (access && apb_req.pwrite && hit_ctrl) begin
			run <= apb_req.pwdata[0];
		end else if (halt_done) begin
			run <= 1'b0;
		end
	end

	always_comb begin
		host_im = '0;
		host_im.en = access && hit_im && !bad && (apb_req.pwrite || !rd_wait);
		host_im.we = apb_req.pwrite;
		host_im.addr[7:0] = apb_req.paddr[9:2];
		host_im.wdata = apb_req.pwdata;
		host_dm = host_im;
		host_dm.en = access && hit_dm && !bad && (apb_req.pwrite || !rd_wait);
	end

	assign reg_idx = apb_req.paddr[6:2];

	always_comb begin
		apb_rsp.pready = access && (!mem_rd || rd_wait);
		apb_rsp.pslverr = access && bad;
		if (hit_ctrl) begin
			apb_rsp.prdata = {31'b0, run};
		end else if (hit_im) begin
			apb_rsp.prdata = im_rdata;
		end else if (hit_dm) begin
			apb_rsp.prdata = dm_rdata;
		end else if (hit_reg) begin
			apb_rsp.prdata = reg_data;
		end else begin
			apb_rsp.prdata = '0;
		end
	end

endmodule

`default_nettype wire

//--- hw/cpu_controller.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_controller (
	input logic clock,
	input logic reset,
	input logic run,
	input logic [cpu_pkg::word_width-1:0] instr,
	output cpu_pkg::phase_e phase,
	output cpu_pkg::ctrl_t ctrl,
	output logic fetch_en,
	output logic ir_load,
	output logic pc_en,
	output logic mem_en,
	output logic halt_done
);

	logic [5:0] opcode;
	logic [4:0] sub_base;
	logic [7:0] sub_ls;

	assign opcode = instr[cpu_pkg::opcode_msb:cpu_pkg::opcode_lsb];
	assign sub_base = instr[cpu_pkg::sub_base_msb:cpu_pkg::sub_base_lsb];
	assign sub_ls = instr[cpu_pkg::sub_ls_msb:cpu_pkg::sub_ls_lsb];

	// one instruction in flight, four cycles each
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			phase <= cpu_pkg::ph_fetch;
		end else if (!run) begin
			phase <= cpu_pkg::ph_fetch;
		end else begin
			case (phase)
				cpu_pkg::ph_fetch: phase <= cpu_pkg::ph_latch;
				cpu_pkg::ph_latch: phase <= cpu_pkg::ph_execute;
				cpu_pkg::ph_execute: phase <= cpu_pkg::ph_writeback;
				default: phase <= cpu_pkg::ph_fetch;
			endcase
		end
	end

	assign fetch_en = run && phase == cpu_pkg::ph_fetch;
	assign ir_load = run && phase == cpu_pkg::ph_latch;
	assign pc_en = run && phase == cpu_pkg::ph_latch;
	assign mem_en = run && phase == cpu_pkg::ph_execute && (ctrl.mem_read || ctrl.mem_write);
	assign halt_done = run && phase == cpu_pkg::ph_writeback && ctrl.halt;

	// anything not listed falls through as a no-op
	always_comb begin
		ctrl = '0;
		case (opcode)
			cpu_pkg::op_ty_base: begin
				ctrl.reg_write = 1'b1;
				case (sub_base)
					cpu_pkg::sub_add: ctrl.alu_op = cpu_pkg::alu_add;
					cpu_pkg::sub_sub: ctrl.alu_op = cpu_pkg::alu_sub;
					cpu_pkg::sub_and: ctrl.alu_op = cpu_pkg::alu_and;
					cpu_pkg::sub_or: ctrl.alu_op = cpu_pkg::alu_or;
					cpu_pkg::sub_xor: ctrl.alu_op = cpu_pkg::alu_xor;
					cpu_pkg::sub_srli: begin
						ctrl.alu_op = cpu_pkg::alu_srl;
						ctrl.imm_sel = cpu_pkg::imm_shamt;
					end
					cpu_pkg::sub_slli: begin
						ctrl.alu_op = cpu_pkg::alu_sll;
						ctrl.imm_sel = cpu_pkg::imm_shamt;
					end
					cpu_pkg::sub_rotri: begin
						ctrl.alu_op = cpu_pkg::alu_rotr;
						ctrl.imm_sel = cpu_pkg::imm_shamt;
					end
					cpu_pkg::sub_break: begin
						ctrl.reg_write = 1'b0;
						ctrl.halt = 1'b1;
					end
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			cpu_pkg::op_addi: begin
				ctrl.imm_sel = cpu_pkg::imm_15;
				ctrl.imm_signed = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			cpu_pkg::op_ori: begin
				ctrl.alu_op = cpu_pkg::alu_or;
				ctrl.imm_sel = cpu_pkg::imm_15;
				ctrl.reg_write = 1'b1;
			end
			cpu_pkg::op_xori: begin
				ctrl.alu_op = cpu_pkg::alu_xor;
				ctrl.imm_sel = cpu_pkg::imm_15;
				ctrl.reg_write = 1'b1;
			end
			cpu_pkg::op_movi: begin
				ctrl.wb_sel = cpu_pkg::wb_imm20;
				ctrl.reg_write = 1'b1;
			end
			cpu_pkg::op_lwi: begin
				ctrl.imm_sel = cpu_pkg::imm_15;
				ctrl.imm_signed = 1'b1;
				ctrl.wb_sel = cpu_pkg::wb_load;
				ctrl.mem_read = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			cpu_pkg::op_swi: begin
				ctrl.imm_sel = cpu_pkg::imm_15;
				ctrl.imm_signed = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			cpu_pkg::op_ty_ls: begin
				ctrl.imm_sel = cpu_pkg::imm_idx;
				if (sub_ls == cpu_pkg::ls_lw) begin
					ctrl.wb_sel = cpu_pkg::wb_load;
					ctrl.mem_read = 1'b1;
					ctrl.reg_write = 1'b1;
				end else if (sub_ls == cpu_pkg::ls_sw) begin
					ctrl.mem_write = 1'b1;
				end
			end
			default: ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/cpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
	input cpu_pkg::ctrl_t ctrl,
	input logic [cpu_pkg::word_width-1:0] ra_data,
	input logic [cpu_pkg::word_width-1:0] rb_data,
	input logic [cpu_pkg::word_width-1:0] ir,
	output logic [cpu_pkg::word_width-1:0] result,
	output logic [cpu_pkg::word_width-1:0] mem_addr
);

	logic [cpu_pkg::word_width-1:0] op_a;
	logic [cpu_pkg::word_width-1:0] op_b;
	logic [cpu_pkg::word_width-1:0] imm15_ext;
	logic [cpu_pkg::word_width-1:0] imm20_ext;
	logic [cpu_pkg::word_width-1:0] alu_out;
	logic [2*cpu_pkg::word_width-1:0] rot;
	logic [14:0] imm15;
	logic [19:0] imm20;
	logic [4:0] shamt;
	logic [1:0] sv;

	assign imm15 = ir[cpu_pkg::imm15_msb:cpu_pkg::imm15_lsb];
	assign imm20 = ir[cpu_pkg::imm20_msb:cpu_pkg::imm20_lsb];
	assign shamt = ir[cpu_pkg::ra_msb:cpu_pkg::ra_lsb];
	assign sv = ir[cpu_pkg::sv_msb:cpu_pkg::sv_lsb];

	// ori and xori zero-extend
	assign imm15_ext = ctrl.imm_signed ? {{17{imm15[14]}}, imm15} : {17'b0, imm15};
	assign imm20_ext = {{12{imm20[19]}}, imm20};

	assign op_a = (ctrl.imm_sel == cpu_pkg::imm_shamt) ? rb_data : ra_data;

	always_comb begin
		case (ctrl.imm_sel)
			cpu_pkg::imm_shamt: op_b = {27'b0, shamt};
			cpu_pkg::imm_15: op_b = imm15_ext;
			cpu_pkg::imm_idx: op_b = rb_data << sv;
			default: op_b = rb_data;
		endcase
	end

	assign rot = {op_a, op_a} >> op_b[4:0];

	always_comb begin
		case (ctrl.alu_op)
			cpu_pkg::alu_sub: alu_out = op_a - op_b;
			cpu_pkg::alu_and: alu_out = op_a & op_b;
			cpu_pkg::alu_or: alu_out = op_a | op_b;
			cpu_pkg::alu_xor: alu_out = op_a ^ op_b;
			cpu_pkg::alu_srl: alu_out = op_a >> op_b[4:0];
			cpu_pkg::alu_sll: alu_out = op_a << op_b[4:0];
			cpu_pkg::alu_rotr: alu_out = rot[cpu_pkg::word_width-1:0];
			default: alu_out = op_a + op_b;
		endcase
	end

	assign result = (ctrl.wb_sel == cpu_pkg::wb_imm20) ? imm20_ext : alu_out;
	// byte address for loads and stores
	assign mem_addr = op_a + op_b;

endmodule

`default_nettype wire

//--- hw/cpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile (
	input logic clock,
	input logic reset,
	input logic [4:0] ra_idx,
	input logic [4:0] rb_idx,
	input logic [4:0] wr_idx,
	input logic [4:0] host_idx,
	input logic wr_en,
	input logic [cpu_pkg::word_width-1:0] wr_data,
	output logic [cpu_pkg::word_width-1:0] ra_data,
	output logic [cpu_pkg::word_width-1:0] rb_data,
	output logic [cpu_pkg::word_width-1:0] host_data
);

	logic [cpu_pkg::word_width-1:0] regs [cpu_pkg::reg_count];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < cpu_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	assign ra_data = regs[ra_idx];
	assign rb_data = regs[rb_idx];
	assign host_data = regs[host_idx];

endmodule

`default_nettype wire

//--- hw/word_memory.sv
`timescale 1ns/1ps
`default_nettype none

module word_memory #(
	parameter int depth_words = 1 << cpu_pkg::mem_addr_width
) (
	input logic clock,
	input cpu_pkg::mem_req_t req,
	output logic [cpu_pkg::word_width-1:0] rdata
);

	logic [cpu_pkg::word_width-1:0] mem [depth_words];

	// read data lands one cycle after the enabled read
	always_ff @(posedge clock) begin
		if (req.en) begin
			if (req.we) begin
				mem[req.addr] <= req.wdata;
			end else begin
				rdata <= mem[req.addr];
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int word_width = 32;
	localparam int mem_addr_width = 10;
	localparam int reg_count = 32;

	// msb and lsb of each instruction field
	localparam int opcode_msb = 30;
	localparam int opcode_lsb = 25;
	localparam int rt_msb = 24;
	localparam int rt_lsb = 20;
	// shifts take their amount from the ra field and their source from rb
	localparam int ra_msb = 19;
	localparam int ra_lsb = 15;
	localparam int rb_msb = 14;
	localparam int rb_lsb = 10;
	localparam int sv_msb = 9;
	localparam int sv_lsb = 8;
	localparam int sub_base_msb = 4;
	localparam int sub_base_lsb = 0;
	localparam int sub_ls_msb = 7;
	localparam int sub_ls_lsb = 0;
	localparam int imm15_msb = 14;
	localparam int imm15_lsb = 0;
	localparam int imm20_msb = 19;
	localparam int imm20_lsb = 0;

	localparam logic [5:0] op_ty_base = 6'b100000;
	localparam logic [5:0] op_addi = 6'b101000;
	localparam logic [5:0] op_ori = 6'b101100;
	localparam logic [5:0] op_xori = 6'b101011;
	localparam logic [5:0] op_movi = 6'b100010;
	localparam logic [5:0] op_lwi = 6'b000010;
	localparam logic [5:0] op_swi = 6'b001010;
	localparam logic [5:0] op_ty_ls = 6'b011100;

	localparam logic [4:0] sub_add = 5'b00000;
	localparam logic [4:0] sub_sub = 5'b00001;
	localparam logic [4:0] sub_and = 5'b00010;
	localparam logic [4:0] sub_xor = 5'b00011;
	localparam logic [4:0] sub_or = 5'b00100;
	localparam logic [4:0] sub_slli = 5'b01000;
	localparam logic [4:0] sub_srli = 5'b01001;
	localparam logic [4:0] sub_break = 5'b01010;
	localparam logic [4:0] sub_rotri = 5'b01011;

	localparam logic [7:0] ls_lw = 8'b00000010;
	localparam logic [7:0] ls_sw = 8'b00001010;

	// byte addresses seen by the host
	localparam logic [11:0] map_ctrl = 12'h000;
	localparam logic [11:0] map_im = 12'h400;
	localparam logic [11:0] map_dm = 12'h800;
	localparam logic [11:0] map_reg = 12'hC00;
	localparam logic [11:0] map_reg_last = 12'hC7C;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_srl, alu_sll, alu_rotr
	} alu_op_e;

	typedef enum logic [1:0] {imm_none, imm_shamt, imm_15, imm_idx} imm_sel_e;
	typedef enum logic [1:0] {wb_alu, wb_imm20, wb_load} wb_sel_e;
	typedef enum logic [1:0] {ph_fetch, ph_latch, ph_execute, ph_writeback} phase_e;

	typedef struct packed {
		alu_op_e alu_op;
		imm_sel_e imm_sel;
		logic imm_signed;
		wb_sel_e wb_sel;
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic halt;
	} ctrl_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [11:0] paddr;
		logic [word_width-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [word_width-1:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic en;
		logic we;
		logic [mem_addr_width-1:0] addr;
		logic [word_width-1:0] wdata;
	} mem_req_t;

endpackage

`default_nettype wire
